// File: pipeline_datapath.f
+incdir+.
lc3b_types.sv
lc3b_pipe_pkg.sv
stage_latch.sv
if_stage.sv
id_stage.sv
exe_stage.sv
mem_stage.sv
wb_stage.sv
pipeline_datapath.sv
tb_pipeline_datapath.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log build.log
verilator --binary -Wno-fatal -f pipeline_datapath.f --top-module tb_pipeline_datapath \
	-o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
{ echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -qx "Test OK" sim.log && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }

// File: tb_lc3b_model.svh
`ifndef TB_LC3B_MODEL_SVH
`define TB_LC3B_MODEL_SVH

	// expected stores in program order
	logic [15:0] exp_addr [$];
	logic [15:0] exp_data [$];
	logic [15:0] model_mem [32768];
	int          n_slots;	// words of program emitted

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// one instruction plus the four nop slots behind it
	task automatic emit(input logic [15:0] instr);
		mem[n_slots] = instr;
		for (int i = 1; i <= 4; i++)
			mem[n_slots + i] = `LC3B_NOP;
		n_slots += 5;
	endtask

	task automatic build_program();
		int         kind;
		int         skip;
		logic [2:0] dr;
		logic [2:0] sa;
		logic [2:0] sb;
		for (int i = 0; i < 32768; i++)
			mem[i] = '0;
		for (int a = 16'hffb0 / 2; a <= 16'hffee / 2; a++)
			mem[a] = 16'($random(seed));	// data region below the r7 base
		n_slots = 0;
		emit({4'b0101, 3'd7, 3'd7, 1'b1, 5'h00});	// and r7, r7, #0
		emit({4'b0001, 3'd7, 3'd7, 1'b1, 5'h10});	// add r7, r7, #-16
		for (int i = 0; i < 60; i++) begin
			kind = rand_below(7);
			dr   = 3'(rand_below(7));	// r7 stays the base
			sa   = 3'(rand_below(8));
			sb   = 3'(rand_below(8));
			case (kind)
				0, 1: begin
					if (rand_below(2) == 1)
						emit({(kind == 0) ? 4'b0001 : 4'b0101, dr, sa, 1'b1, 5'(rand_below(32))});
					else
						emit({(kind == 0) ? 4'b0001 : 4'b0101, dr, sa, 3'b000, sb});
				end
				2: emit({4'b1001, dr, sa, 6'h3f});
				3: emit({4'b0110, dr, 3'd7, 1'b1, 5'(rand_below(32))});	// offset -32..-1
				4: emit({4'b0111, sa, 3'd7, 1'b1, 5'(rand_below(32))});
				5: emit({4'b1110, dr, 9'(rand_below(512))});
				default: begin
					skip = 1 + rand_below(2);
					emit({4'b0000, 3'(rand_below(8)), 9'(4 + 5 * skip)});	// land on a group start
				end
			endcase
		end
		for (int r = 0; r < 8; r++)
			emit({4'b0111, 3'(r), 3'd7, 6'(r)});	// dump r0..r7 to 0xfff0..0xfffe
		emit({4'b0000, 3'b111, 9'h1ff});	// spin in place
	endtask

	// architectural model, one instruction per step
	task automatic run_model();
		logic [15:0] regs [8];
		logic [2:0]  cc;
		logic [15:0] pc;
		logic [15:0] ir;
		logic [15:0] next;
		logic [15:0] opb;
		logic [15:0] off6;
		logic [15:0] off9;
		logic [15:0] addr;
		logic [15:0] res;
		logic        writes;
		logic        halted;
		int          steps;
		for (int i = 0; i < 32768; i++)
			model_mem[i] = mem[i];
		for (int i = 0; i < 8; i++)
			regs[i] = '0;
		cc     = 3'b010;
		pc     = `LC3B_RESET_PC;
		halted = 1'b0;
		steps  = 0;
		while (!halted && steps < 20000) begin
			ir     = model_mem[pc[15:1]];
			next   = pc + 16'd2;
			off6   = {{9{ir[5]}}, ir[5:0], 1'b0};
			off9   = {{6{ir[8]}}, ir[8:0], 1'b0};
			opb    = ir[5] ? {{11{ir[4]}}, ir[4:0]} : regs[ir[2:0]];
			addr   = regs[ir[8:6]] + off6;
			res    = '0;
			writes = 1'b0;
			case (ir[15:12])
				4'b0001: begin
					res    = regs[ir[8:6]] + opb;
					writes = 1'b1;
				end
				4'b0101: begin
					res    = regs[ir[8:6]] & opb;
					writes = 1'b1;
				end
				4'b1001: begin
					res    = ~regs[ir[8:6]];
					writes = 1'b1;
				end
				4'b0110: begin
					res    = model_mem[addr[15:1]];
					writes = 1'b1;
				end
				4'b0111: begin
					model_mem[addr[15:1]] = regs[ir[11:9]];
					exp_addr.push_back(addr);
					exp_data.push_back(regs[ir[11:9]]);
				end
				4'b1110: regs[ir[11:9]] = next + off9;	// cc untouched
				4'b0000: begin
					if (ir[11:9] != 3'b000 && next + off9 == pc)
						halted = 1'b1;
					else if (|(ir[11:9] & cc))
						next = next + off9;
				end
				default: ;
			endcase
			if (writes) begin
				regs[ir[11:9]] = res;
				cc = res[15] ? 3'b100 : (res == 16'h0000) ? 3'b010 : 3'b001;
			end
			pc = next;
			steps++;
		end
	endtask

`endif

// File: tb_pipeline_datapath.sv
`include "lc3b_consts.svh"

module tb_pipeline_datapath;

	logic                 clk;
	logic                 reset;
	lc3b_types::lc3b_word if_memaddr;
	logic                 if_memread;
	logic                 if_mem_resp;
	lc3b_types::lc3b_word if_mem_rdata;
	lc3b_types::lc3b_word mem_memaddr;
	logic                 mem_memread;
	logic                 mem_memwrite;
	lc3b_types::lc3b_word mem_mem_wdata;
	logic                 mem_mem_resp;
	lc3b_types::lc3b_word mem_mem_rdata;

	logic [15:0] mem [32768];	// word indexed memory behind both ports
	integer      seed;
	int          errors;
	int          stores_seen;
	int          cycles;
	int          cycle_limit;
	logic        first_fetch_seen;
	logic        if_pending;
	int          if_wait;
	logic        d_pending;
	int          d_wait;

	`include "tb_lc3b_model.svh"

	pipeline_datapath u_pipeline_datapath (
		.clk(clk), .reset(reset),
		.if_memaddr(if_memaddr), .if_memread(if_memread),
		.if_mem_resp(if_mem_resp), .if_mem_rdata(if_mem_rdata),
		.mem_memaddr(mem_memaddr), .mem_memread(mem_memread), .mem_memwrite(mem_memwrite),
		.mem_mem_wdata(mem_mem_wdata), .mem_mem_resp(mem_mem_resp), .mem_mem_rdata(mem_mem_rdata)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		if (reset)
			cycles <= 0;
		else
			cycles <= cycles + 1;
	end

	task automatic check_store(input logic [15:0] addr, input logic [15:0] data);
		if (stores_seen >= exp_addr.size()) begin
			$display("unexpected extra store of %h to %h", data, addr);
			errors++;
		end else begin
			if (addr !== exp_addr[stores_seen]) begin
				$display("MISMATCH mem_memaddr store %0d: got %h expected %h",
					stores_seen, addr, exp_addr[stores_seen]);
				errors++;
			end
			if (data !== exp_data[stores_seen]) begin
				$display("MISMATCH mem_mem_wdata store %0d: got %h expected %h",
					stores_seen, data, exp_data[stores_seen]);
				errors++;
			end
		end
		stores_seen++;
	endtask

	task automatic serve_fetch();
		if (if_pending && !if_memread) begin
			$display("fetch request at %h dropped before its response", if_memaddr);
			errors++;
			if_pending = 1'b0;
		end else if (if_pending) begin
			if (if_wait > 1) begin
				if_wait--;
			end else begin
				if_mem_rdata = mem[if_memaddr[15:1]];
				if_mem_resp  = 1'b1;
				if_pending   = 1'b0;
			end
		end else if (if_memread) begin
			if_pending = 1'b1;
			if_wait    = 1 + rand_below(3);	// 1 to 3 cycles
		end
	endtask

	task automatic serve_data();
		if (d_pending && !(mem_memread || mem_memwrite)) begin
			$display("data request at %h dropped before its response", mem_memaddr);
			errors++;
			d_pending = 1'b0;
		end else if (d_pending) begin
			if (d_wait > 1) begin
				d_wait--;
			end else begin
				if (mem_memwrite) begin
					check_store(mem_memaddr, mem_mem_wdata);	// counted once at the response
					mem[mem_memaddr[15:1]] = mem_mem_wdata;
				end else begin
					mem_mem_rdata = mem[mem_memaddr[15:1]];
				end
				mem_mem_resp = 1'b1;
				d_pending    = 1'b0;
			end
		end else if (mem_memread || mem_memwrite) begin
			d_pending = 1'b1;
			d_wait    = 1 + rand_below(3);
		end
	endtask

	// memory responder and reset checks on the falling edge
	always @(negedge clk) begin
		if ((reset || cycles <= 1) && (mem_memread || mem_memwrite)) begin
			$display("data request raised during reset or the cycle after it");
			errors++;
		end
		if (reset && if_memread) begin
			$display("fetch request raised during reset");
			errors++;
		end
		if (!reset && if_memread && !first_fetch_seen) begin
			first_fetch_seen = 1'b1;
			if (if_memaddr !== 16'h0000) begin
				$display("MISMATCH if_memaddr first fetch: got %h expected %h",
					if_memaddr, 16'h0000);
				errors++;
			end
		end
		if_mem_resp  = 1'b0;
		mem_mem_resp = 1'b0;
		if (reset) begin
			if_pending = 1'b0;
			d_pending  = 1'b0;
		end else begin
			serve_fetch();
			serve_data();
		end
	end

	initial begin
		clk              = 1'b0;
		reset            = 1'b1;
		if_mem_resp      = 1'b0;
		if_mem_rdata     = '0;
		mem_mem_resp     = 1'b0;
		mem_mem_rdata    = '0;
		seed             = 32'he7e0_c891;
		errors           = 0;
		stores_seen      = 0;
		first_fetch_seen = 1'b0;
		if_pending       = 1'b0;
		d_pending        = 1'b0;
		build_program();
		run_model();
		cycle_limit = n_slots * 8 + 300;
		repeat (10) @(negedge clk);
		reset <= 1'b0;
		while (stores_seen < exp_addr.size() && cycles < cycle_limit)
			@(posedge clk);
		if (stores_seen < exp_addr.size()) begin
			$display("timeout after %0d cycles, program did not finish", cycles);
			errors++;
		end else begin
			repeat (40) @(posedge clk);	// catch duplicated stores while spinning
		end
		$display("errors %0d, stores %0d of %0d, cycles %0d",
			errors, stores_seen, exp_addr.size(), cycles);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule : tb_pipeline_datapath

// File: pipeline_datapath.sv
module pipeline_datapath (
	input  logic                 clk,
	input  logic                 reset,

	// fetch port
	output lc3b_types::lc3b_word if_memaddr,
	output logic                 if_memread,
	input  logic                 if_mem_resp,
	input  lc3b_types::lc3b_word if_mem_rdata,

	// data port
	output lc3b_types::lc3b_word mem_memaddr,
	output logic                 mem_memread,
	output logic                 mem_memwrite,
	output lc3b_types::lc3b_word mem_mem_wdata,
	input  logic                 mem_mem_resp,
	input  lc3b_types::lc3b_word mem_mem_rdata
);

	localparam int pkt_w = $bits(lc3b_pipe_pkg::lc3b_ipacket);

	logic pipe_stall, mem_busy;

	// if
	lc3b_types::lc3b_word if_instruction, if_pc_next;

	// id
	lc3b_types::lc3b_word       id_instruction, id_pc_next;
	lc3b_pipe_pkg::lc3b_ipacket id_ipacket;
	lc3b_types::lc3b_word       id_sr1, id_sr2, id_sext;

	// exe
	lc3b_pipe_pkg::lc3b_ipacket ex_ipacket;
	lc3b_types::lc3b_word       ex_sr1, ex_sr2, ex_sext;
	lc3b_types::lc3b_word       ex_alu, ex_addr, ex_store;

	// mem
	lc3b_pipe_pkg::lc3b_ipacket mem_ipacket;
	lc3b_types::lc3b_word       mem_alu, mem_addr, mem_store, mem_data;

	// wb
	lc3b_pipe_pkg::lc3b_ipacket wb_ipacket;
	lc3b_types::lc3b_word       wb_alu, wb_mem, wb_addr, wb_data, br_target;
	lc3b_types::lc3b_reg        wb_dr;
	logic                       wb_load_regfile, br_taken;

	if_stage if_module (
		.clk(clk), .reset(reset),
		.mem_busy(mem_busy), .br_taken(br_taken), .br_target(br_target),
		.if_mem_resp(if_mem_resp), .if_mem_rdata(if_mem_rdata),
		.if_memaddr(if_memaddr), .if_memread(if_memread),
		.instruction(if_instruction), .pc_next(if_pc_next), .pipe_stall(pipe_stall)
	);

	stage_latch #(.width(32)) if_id (
		.clk(clk), .reset(reset), .stall(pipe_stall),
		.d({if_pc_next, if_instruction}), .q({id_pc_next, id_instruction})
	);

	id_stage id_module (
		.clk(clk), .reset(reset),
		.instruction(id_instruction), .pc_next(id_pc_next),
		.wb_dr(wb_dr), .wb_data(wb_data), .load_regfile(wb_load_regfile),
		.ipacket(id_ipacket), .sr1_out(id_sr1), .sr2_out(id_sr2), .sext_out(id_sext)
	);

	stage_latch #(.width(pkt_w + 48)) id_exe (
		.clk(clk), .reset(reset), .stall(pipe_stall),
		.d({id_ipacket, id_sr1, id_sr2, id_sext}), .q({ex_ipacket, ex_sr1, ex_sr2, ex_sext})
	);

	exe_stage exe_module (
		.ipacket(ex_ipacket), .sr1(ex_sr1), .sr2(ex_sr2), .sext(ex_sext),
		.alu_out(ex_alu), .addr_out(ex_addr), .store_data(ex_store)
	);

	stage_latch #(.width(pkt_w + 48)) exe_mem (
		.clk(clk), .reset(reset), .stall(pipe_stall),
		.d({ex_ipacket, ex_alu, ex_addr, ex_store}),
		.q({mem_ipacket, mem_alu, mem_addr, mem_store})
	);

	mem_stage mem_module (
		.clk(clk), .reset(reset), .ipacket(mem_ipacket),
		.alu_in(mem_alu), .addr_in(mem_addr), .store_data(mem_store),
		.mem_mem_resp(mem_mem_resp), .mem_mem_rdata(mem_mem_rdata),
		.mem_memaddr(mem_memaddr), .mem_memread(mem_memread), .mem_memwrite(mem_memwrite),
		.mem_mem_wdata(mem_mem_wdata), .mem_data_out(mem_data), .mem_busy(mem_busy)
	);

	stage_latch #(.width(pkt_w + 48)) mem_wb (
		.clk(clk), .reset(reset), .stall(pipe_stall),
		.d({mem_ipacket, mem_alu, mem_data, mem_addr}),
		.q({wb_ipacket, wb_alu, wb_mem, wb_addr})
	);

	wb_stage wb_module (
		.clk(clk), .reset(reset), .pipe_stall(pipe_stall), .ipacket(wb_ipacket),
		.alu_in(wb_alu), .mem_in(wb_mem), .addr_in(wb_addr),
		.wb_data(wb_data), .wb_dr(wb_dr), .load_regfile(wb_load_regfile),
		.br_taken(br_taken), .br_target(br_target)
	);

endmodule : pipeline_datapath

// File: wb_stage.sv
module wb_stage (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      pipe_stall,
	input  lc3b_pipe_pkg::lc3b_ipacket ipacket,
	input  lc3b_types::lc3b_word      alu_in,
	input  lc3b_types::lc3b_word      mem_in,
	input  lc3b_types::lc3b_word      addr_in,
	output lc3b_types::lc3b_word      wb_data,
	output lc3b_types::lc3b_reg       wb_dr,
	output logic                      load_regfile,
	output logic                      br_taken,
	output lc3b_types::lc3b_word      br_target
);

	logic [2:0] cc;	// n z p
	logic [2:0] cc_new;

	always_comb begin
		case (ipacket.wb_sel)
			lc3b_pipe_pkg::wb_mem:  wb_data = mem_in;
			lc3b_pipe_pkg::wb_addr: wb_data = addr_in;
			default:                wb_data = alu_in;
		endcase
	end

	assign cc_new = wb_data[15] ? 3'b100 : (wb_data == '0) ? 3'b010 : 3'b001;

	always_ff @(posedge clk) begin
		if (reset)
			cc <= 3'b010;
		else if (!pipe_stall && ipacket.set_cc)
			cc <= cc_new;
	end

	assign wb_dr        = ipacket.dr;
	assign load_regfile = ipacket.load_regfile && !pipe_stall;	// one write per instruction
	assign br_taken     = ipacket.is_branch && |(ipacket.nzp & cc);
	assign br_target    = addr_in;

endmodule : wb_stage

// File: mem_stage.sv
module mem_stage (
	input  logic                      clk,
	input  logic                      reset,
	input  lc3b_pipe_pkg::lc3b_ipacket ipacket,
	input  lc3b_types::lc3b_word      alu_in,
	input  lc3b_types::lc3b_word      addr_in,
	input  lc3b_types::lc3b_word      store_data,
	input  logic                      mem_mem_resp,
	input  lc3b_types::lc3b_word      mem_mem_rdata,
	output lc3b_types::lc3b_word      mem_memaddr,
	output logic                      mem_memread,
	output logic                      mem_memwrite,
	output lc3b_types::lc3b_word      mem_mem_wdata,
	output lc3b_types::lc3b_word      mem_data_out,
	output logic                      mem_busy
);

	logic                 access;
	logic                 done;	// access finished, waiting on the fetch side
	logic                 done_hit;
	lc3b_types::lc3b_word done_pc;	// tags which instruction finished
	lc3b_types::lc3b_word rdata_q;

	assign access   = ipacket.mem_read || ipacket.mem_write;
	// a new packet in the latch never matches the tag
	assign done_hit = done && (done_pc == ipacket.pc);

	assign mem_memaddr   = addr_in;
	assign mem_mem_wdata = store_data;
	assign mem_memread   = ipacket.mem_read && !done_hit;
	assign mem_memwrite  = ipacket.mem_write && !done_hit;
	assign mem_busy      = access && !done_hit && !mem_mem_resp;

	// read word straight from the port in the response cycle, held after
	assign mem_data_out = !ipacket.mem_read ? alu_in :
		done_hit ? rdata_q : mem_mem_rdata;

	always_ff @(posedge clk) begin
		if (reset)
			done <= 1'b0;
		else if (access && !done_hit && mem_mem_resp)
			done <= 1'b1;
		else if (!done_hit)
			done <= 1'b0;	// latch moved on
	end

	always_ff @(posedge clk) begin
		if (mem_mem_resp) begin
			rdata_q <= mem_mem_rdata;
			done_pc <= ipacket.pc;
		end
	end

endmodule : mem_stage

// File: exe_stage.sv
module exe_stage (
	input  lc3b_pipe_pkg::lc3b_ipacket ipacket,
	input  lc3b_types::lc3b_word      sr1,
	input  lc3b_types::lc3b_word      sr2,
	input  lc3b_types::lc3b_word      sext,
	output lc3b_types::lc3b_word      alu_out,
	output lc3b_types::lc3b_word      addr_out,
	output lc3b_types::lc3b_word      store_data
);

	lc3b_types::lc3b_word alu_b;
	lc3b_types::lc3b_word addr_base;
	logic                 base_reg;

	// imm5 or register operand
	assign alu_b = ipacket.use_imm ? sext : sr2;

	always_comb begin
		case (ipacket.aluop)
			lc3b_types::alu_add:  alu_out = sr1 + alu_b;
			lc3b_types::alu_and:  alu_out = sr1 & alu_b;
			lc3b_types::alu_not:  alu_out = ~sr1;
			lc3b_types::alu_pass: alu_out = alu_b;
			default:              alu_out = alu_b;
		endcase
	end

	// ldr/str are base + offset6, br/lea are pc relative
	assign base_reg  = (ipacket.opcode == lc3b_types::op_ldr) ||
		(ipacket.opcode == lc3b_types::op_str);
	assign addr_base = base_reg ? sr1 : ipacket.pc;
	assign addr_out  = addr_base + sext;	// sext already shifted in decode

	assign store_data = sr2;

endmodule : exe_stage

// File: id_stage.sv
`include "lc3b_consts.svh"

module id_stage (
	input  logic                      clk,
	input  logic                      reset,
	input  lc3b_types::lc3b_word      instruction,
	input  lc3b_types::lc3b_word      pc_next,
	input  lc3b_types::lc3b_reg       wb_dr,
	input  lc3b_types::lc3b_word      wb_data,
	input  logic                      load_regfile,
	output lc3b_pipe_pkg::lc3b_ipacket ipacket,
	output lc3b_types::lc3b_word      sr1_out,
	output lc3b_types::lc3b_word      sr2_out,
	output lc3b_types::lc3b_word      sext_out
);

	lc3b_types::lc3b_word   regs [`LC3B_NUM_REGS];
	lc3b_types::lc3b_opcode opcode;
	lc3b_types::lc3b_reg    sr1;
	lc3b_types::lc3b_reg    sr2;

	assign opcode = lc3b_types::lc3b_opcode'(instruction[15:12]);
	assign sr1    = instruction[8:6];
	// str reads its source register through the sr2 port
	assign sr2    = (opcode == lc3b_types::op_str) ? instruction[11:9] : instruction[2:0];

	always_comb begin
		ipacket        = '0;
		ipacket.pc     = pc_next;
		ipacket.opcode = opcode;
		ipacket.dr     = instruction[11:9];
		ipacket.aluop  = lc3b_types::alu_pass;
		ipacket.wb_sel = lc3b_pipe_pkg::wb_alu;
		sext_out       = {{7{instruction[8]}}, instruction[8:0]} << 1;	// pcoffset9
		case (opcode)
			lc3b_types::op_add, lc3b_types::op_and: begin
				ipacket.aluop        = (opcode == lc3b_types::op_add) ?
					lc3b_types::alu_add : lc3b_types::alu_and;
				ipacket.use_imm      = instruction[5];
				ipacket.load_regfile = 1'b1;
				ipacket.set_cc       = 1'b1;
				sext_out             = {{11{instruction[4]}}, instruction[4:0]};
			end
			lc3b_types::op_not: begin
				ipacket.aluop        = lc3b_types::alu_not;
				ipacket.load_regfile = 1'b1;
				ipacket.set_cc       = 1'b1;
			end
			lc3b_types::op_ldr, lc3b_types::op_str: begin
				ipacket.mem_read     = (opcode == lc3b_types::op_ldr);
				ipacket.mem_write    = (opcode == lc3b_types::op_str);
				ipacket.load_regfile = (opcode == lc3b_types::op_ldr);
				ipacket.set_cc       = (opcode == lc3b_types::op_ldr);
				ipacket.wb_sel       = lc3b_pipe_pkg::wb_mem;
				sext_out             = {{10{instruction[5]}}, instruction[5:0]} << 1;
			end
			lc3b_types::op_lea: begin
				ipacket.wb_sel       = lc3b_pipe_pkg::wb_addr;
				ipacket.load_regfile = 1'b1;	// lc3b lea leaves cc alone
			end
			lc3b_types::op_br: begin
				ipacket.is_branch = 1'b1;
				ipacket.nzp       = instruction[11:9];
			end
			default: ;	// unsupported opcodes pass as nops
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `LC3B_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (load_regfile) begin
			regs[wb_dr] <= wb_data;
		end
	end

	// write-first read
	assign sr1_out = (load_regfile && wb_dr == sr1) ? wb_data : regs[sr1];
	assign sr2_out = (load_regfile && wb_dr == sr2) ? wb_data : regs[sr2];

endmodule : id_stage

// File: if_stage.sv
`include "lc3b_consts.svh"

module if_stage (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 mem_busy,
	input  logic                 br_taken,
	input  lc3b_types::lc3b_word br_target,
	input  logic                 if_mem_resp,
	input  lc3b_types::lc3b_word if_mem_rdata,
	output lc3b_types::lc3b_word if_memaddr,
	output logic                 if_memread,
	output lc3b_types::lc3b_word instruction,
	output lc3b_types::lc3b_word pc_next,
	output logic                 pipe_stall
);

	lc3b_types::lc3b_word pc;
	lc3b_types::lc3b_word ibuf;	// fetched word
	logic                 buf_valid;
	logic                 req;

	assign if_memaddr  = pc;
	assign if_memread  = req;
	assign instruction = ibuf;
	assign pc_next     = pc + 16'd2;

	// nothing moves until the word is in hand and the data port is idle
	assign pipe_stall = !buf_valid || mem_busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc        <= `LC3B_RESET_PC;
			ibuf      <= `LC3B_NOP;
			buf_valid <= 1'b0;
			req       <= 1'b0;
		end else begin
			if (req && if_mem_resp) begin
				ibuf      <= if_mem_rdata;	// kept through any stall
				buf_valid <= 1'b1;
				req       <= 1'b0;
			end else if (!buf_valid) begin
				req <= 1'b1;	// first fetch after reset
			end
			// word consumed by if_id this edge
			if (!pipe_stall) begin
				pc        <= br_taken ? br_target : pc_next;
				buf_valid <= 1'b0;
				req       <= 1'b1;
			end
		end
	end

endmodule : if_stage

// File: stage_latch.sv
module stage_latch #(
	parameter int width = 32
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             stall,
	input  logic [width-1:0] d,
	output logic [width-1:0] q
);

	// packet sits in the upper bits, data words below
	// a zero packet decodes as a nop with every control bit clear
	always_ff @(posedge clk) begin
		if (reset) begin
			q <= '0;
		end else if (!stall) begin
			q <= d;	// advance
		end
		// stalled: hold
	end

endmodule : stage_latch

// File: lc3b_pipe_pkg.sv
package lc3b_pipe_pkg;

	// which value goes back to the register file
	typedef enum logic [1:0] {
		wb_alu  = 2'b00,
		wb_mem  = 2'b01,
		wb_addr = 2'b10	// lea result
	} wb_src;

	// control word that follows an instruction down the pipe
	// all-zero is the nop packet
	typedef struct packed {
		lc3b_types::lc3b_word   pc;	// address of the following instruction
		lc3b_types::lc3b_opcode opcode;
		lc3b_types::lc3b_reg    dr;
		logic [2:0]             nzp;	// branch condition mask
		lc3b_types::lc3b_aluop  aluop;
		logic                   use_imm;
		wb_src                  wb_sel;
		logic                   load_regfile;
		logic                   set_cc;
		logic                   mem_read;
		logic                   mem_write;
		logic                   is_branch;
	} lc3b_ipacket;

endpackage : lc3b_pipe_pkg

// File: lc3b_types.sv
package lc3b_types;

	// data words and byte addresses
	typedef logic [15:0] lc3b_word;

	// register index
	typedef logic [2:0] lc3b_reg;

	// opcode field, bits 15:12 of the instruction
	// only the implemented subset is listed
	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001,
		op_lea = 4'b1110
	} lc3b_opcode;

	// alu function select
	typedef enum logic [1:0] {
		alu_add  = 2'b00,
		alu_and  = 2'b01,
		alu_not  = 2'b10,
		alu_pass = 2'b11	// second operand straight through
	} lc3b_aluop;

endpackage : lc3b_types

// File: lc3b_consts.svh
`ifndef LC3B_CONSTS_SVH
`define LC3B_CONSTS_SVH

// first fetch address out of reset
`define LC3B_RESET_PC 16'h0000

// architectural registers R0..R7
`define LC3B_NUM_REGS 8

// BR with nzp = 000, never taken
`define LC3B_NOP 16'h0000

`endif
